// ==== flist.f ====
src/lc3b_types.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/mem.sv
src/arbiter.sv
src/write_back.sv
src/mp3.sv
verification/mp3_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mp3_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/mp3_tb.sv ====
module mp3_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_tests = 5;
	localparam int max_instr = 24;
	localparam int worst_delay = 4;
	localparam int period = 8;
	// fetch, load and store accesses per instruction, plus handshake gaps
	localparam int timeout = n_tests * (max_instr * 3 * (worst_delay + 2) + 10) * period;
	localparam lc3b_types::lc3b_word result_line = 16'h0030;
	localparam lc3b_types::lc3b_word nop = 16'h8000;
	localparam lc3b_types::lc3b_word halt = {lc3b_types::op_br, 3'b111, 9'h1ff};

	logic clk;
	logic reset;
	logic pmem_resp;
	lc3b_types::lc3b_c_block pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_types::lc3b_word pmem_address;
	lc3b_types::lc3b_c_block pmem_wdata;

	// test table
	string names [n_tests];
	lc3b_types::lc3b_word progs [n_tests][max_instr];
	lc3b_types::lc3b_word dinit [n_tests][8];
	int res_off [n_tests];
	lc3b_types::lc3b_word res_val [n_tests];
	lc3b_types::lc3b_word alu_seq [7];
	int cur;

	// memory model state
	lc3b_types::lc3b_c_block mem_lines [256];
	logic busy;
	logic [1:0] kind;
	lc3b_types::lc3b_word req_addr;
	int count;
	integer seed;
	logic wr_seen;
	lc3b_types::lc3b_word wr_addr;
	logic [1:0] prev_kind;
	lc3b_types::lc3b_word prev_addr;
	logic [1:0] rd_kind;
	lc3b_types::lc3b_word rd_addr;

	mp3 uut (
		.clk, .reset, .pmem_resp, .pmem_rdata,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata
	);

	function automatic lc3b_types::lc3b_word add_rr(int d, int a, int b);
		return {lc3b_types::op_add, 3'(d), 3'(a), 3'b000, 3'(b)};
	endfunction

	function automatic lc3b_types::lc3b_word add_ri(int d, int a, logic [4:0] imm);
		return {lc3b_types::op_add, 3'(d), 3'(a), 1'b1, imm};
	endfunction

	function automatic lc3b_types::lc3b_word and_rr(int d, int a, int b);
		return {lc3b_types::op_and, 3'(d), 3'(a), 3'b000, 3'(b)};
	endfunction

	function automatic lc3b_types::lc3b_word and_ri(int d, int a, logic [4:0] imm);
		return {lc3b_types::op_and, 3'(d), 3'(a), 1'b1, imm};
	endfunction

	function automatic lc3b_types::lc3b_word not_r(int d, int a);
		return {lc3b_types::op_not, 3'(d), 3'(a), 6'h3f};
	endfunction

	function automatic lc3b_types::lc3b_word branch(logic [2:0] nzp, logic [8:0] off);
		return {lc3b_types::op_br, nzp, off};
	endfunction

	function automatic lc3b_types::lc3b_word load_word(int d, int base, logic [5:0] off);
		return {lc3b_types::op_ldr, 3'(d), 3'(base), off};
	endfunction

	function automatic lc3b_types::lc3b_word store_word(int s, int base, logic [5:0] off);
		return {lc3b_types::op_str, 3'(s), 3'(base), off};
	endfunction

	// code in lines 0 to 2, data in line 3, a pattern elsewhere
	function automatic lc3b_types::lc3b_word image_word(int t, int l, int w);
		int idx;
		idx = l * 8 + w;
		if (idx < max_instr)
			return progs[t][idx];
		if (l == 3)
			return dinit[t][w];
		return lc3b_types::lc3b_word'(idx) ^ 16'h5a5a;
	endfunction

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_word(string name, lc3b_types::lc3b_word exp,
			lc3b_types::lc3b_word act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_rw(string name, logic [1:0] exp, logic [1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected read/write %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic build_table();
		int p;
		for (int t = 0; t < n_tests; t++) begin
			for (int i = 0; i < max_instr; i++)
				progs[t][i] = nop;
			for (int w = 0; w < 8; w++)
				dinit[t][w] = {4'(t), 4'h0, 8'(w * 17)};
		end
		alu_seq[0] = add_ri(1, 0, 5'd7);
		alu_seq[1] = add_ri(2, 0, 5'h1d);
		alu_seq[2] = add_rr(3, 1, 2);
		alu_seq[3] = and_ri(4, 3, 5'd6);
		alu_seq[4] = not_r(5, 4);
		alu_seq[5] = and_rr(6, 5, 1);
		alu_seq[6] = add_rr(6, 6, 5);
		// back to back
		names[0] = "alu_chain";
		for (int i = 0; i < 7; i++)
			progs[0][i] = alu_seq[i];
		progs[0][7] = store_word(6, 0, 6'd30);
		progs[0][8] = halt;
		res_off[0] = 30;
		res_val[0] = 16'hfffe;
		// same ops with two no-ops after each
		names[1] = "alu_spaced";
		p = 0;
		for (int i = 0; i < 7; i++) begin
			progs[1][p] = alu_seq[i];
			p += 3;
		end
		progs[1][p] = store_word(6, 0, 6'd31);
		progs[1][p + 1] = halt;
		res_off[1] = 31;
		res_val[1] = 16'hfffe;
		names[2] = "branches";
		progs[2][0] = add_ri(1, 0, 5'h1e);
		progs[2][1] = branch(3'b100, 9'd1);
		progs[2][2] = add_ri(1, 1, 5'd5);
		progs[2][3] = add_ri(2, 0, 5'd1);
		progs[2][4] = branch(3'b010, 9'd1);
		progs[2][5] = add_ri(1, 1, 5'd3);
		progs[2][6] = branch(3'b001, 9'd1);
		progs[2][7] = store_word(0, 0, 6'd31);
		progs[2][8] = store_word(1, 0, 6'd31);
		progs[2][9] = halt;
		res_off[2] = 31;
		res_val[2] = 16'h0001;
		names[3] = "load_use";
		progs[3][0] = load_word(1, 0, 6'd24);
		progs[3][1] = load_word(3, 0, 6'd25);
		progs[3][2] = add_ri(2, 1, 5'd1);
		progs[3][3] = add_rr(2, 2, 3);
		progs[3][4] = store_word(2, 0, 6'd28);
		progs[3][5] = halt;
		dinit[3][0] = 16'h1234;
		dinit[3][1] = 16'h0f00;
		res_off[3] = 28;
		res_val[3] = 16'h2135;
		names[4] = "store_merge";
		progs[4][0] = not_r(1, 0);
		progs[4][1] = and_ri(2, 1, 5'h18);
		progs[4][2] = store_word(2, 0, 6'd29);
		progs[4][3] = halt;
		res_off[4] = 29;
		res_val[4] = 16'hfff8;
	endtask

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// line memory with a random response delay of 1 to 4 cycles
	always @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			pmem_resp <= 1'b0;
			wr_seen <= 1'b0;
			prev_kind <= 2'b00;
			prev_addr <= '0;
			for (int l = 0; l < 256; l++)
				for (int w = 0; w < 8; w++)
					mem_lines[l][16*w +: 16] <= image_word(cur, l, w);
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;
		end else if (busy) begin
			if ({pmem_read, pmem_write} !== kind || pmem_address !== req_addr) begin
				$display("memory request changed before its response arrived");
				stop_on_error();
			end
			if (count == 0) begin
				busy <= 1'b0;
				pmem_resp <= 1'b1;
				prev_kind <= kind;
				prev_addr <= req_addr;
				if (kind == 2'b10) begin
					pmem_rdata <= mem_lines[req_addr[11:4]];
				end else begin
					mem_lines[req_addr[11:4]] <= pmem_wdata;
					if (!wr_seen) begin
						wr_seen <= 1'b1;
						wr_addr <= req_addr;
						rd_kind <= prev_kind;
						rd_addr <= prev_addr;
					end
				end
			end else begin
				count <= count - 1;
			end
		end else if (pmem_read || pmem_write) begin
			if (pmem_read && pmem_write) begin
				$display("memory read and write requested at once");
				stop_on_error();
			end
			busy <= 1'b1;
			kind <= {pmem_read, pmem_write};
			req_addr <= pmem_address;
			count <= $random(seed) & 32'd3;
		end
	end

	initial begin
		#(timeout);
		$display("no result store arrived in time");
		stop_on_error();
	end

	initial begin
		seed = 32'hafc4_aa5e;
		reset <= 1'b1;
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
		cur = 0;
		build_table();
		for (int t = 0; t < n_tests; t++) begin
			if (t > 0)
				@(posedge clk);
			cur = t;
			reset <= 1'b1;
			repeat (2) @(posedge clk);
			reset <= 1'b0;
			while (!wr_seen)
				@(negedge clk);
			check_word(names[t], result_line, wr_addr);
			// a store reads its line right before it writes it back
			check_rw(names[t], 2'b10, rd_kind);
			check_word(names[t], result_line, rd_addr);
			// stored word lands, the other seven stay as loaded
			for (int w = 0; w < 8; w++) begin
				if (w + 24 == res_off[t])
					check_word(names[t], res_val[t], mem_lines[3][16*w +: 16]);
				else
					check_word(names[t], dinit[t][w], mem_lines[3][16*w +: 16]);
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule : mp3_tb

// ==== src/mp3.sv ====
module mp3 (
	input logic clk,
	input logic reset,
	input logic pmem_resp,
	input lc3b_types::lc3b_c_block pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_c_block pmem_wdata
);
	logic load_regs;
	logic dep_stall;
	logic br_taken;
	lc3b_types::lc3b_word target_pc;

	// stage registers
	lc3b_types::lc3b_word f_de_npc, f_de_ir;
	logic f_de_valid;
	lc3b_types::lc3b_word de_ex_npc, de_ex_ir, de_ex_sr1, de_ex_sr2;
	lc3b_types::lc3b_control_word de_ex_cw;
	lc3b_types::lc3b_nzp de_ex_cc;
	lc3b_types::lc3b_reg de_ex_dr;
	logic de_ex_valid;
	lc3b_types::lc3b_word ex_mem_address, ex_mem_result, ex_mem_data;
	lc3b_types::lc3b_control_word ex_mem_cw;
	lc3b_types::lc3b_reg ex_mem_dr;
	logic ex_mem_valid;
	lc3b_types::lc3b_word mem_wb_result, mem_wb_data;
	lc3b_types::lc3b_control_word mem_wb_cw;
	lc3b_types::lc3b_reg mem_wb_dr;
	logic mem_wb_valid;

	// register file and dependency checks
	lc3b_types::lc3b_reg sr1_id, sr2_id;
	lc3b_types::lc3b_word sr1_data, sr2_data;
	lc3b_types::lc3b_nzp cc_data;
	lc3b_types::lc3b_reg ex_dr, mem_dr, wb_dr;
	logic ex_ld_reg, mem_ld_reg, wb_ld_reg;
	logic ex_ld_cc, mem_ld_cc, wb_ld_cc;

	// memory side
	logic icache_pmem_read, icache_pmem_resp;
	lc3b_types::lc3b_word icache_pmem_address;
	logic dcache_pmem_read, dcache_pmem_write, dcache_pmem_resp;
	lc3b_types::lc3b_word dcache_pmem_address;

	arbiter arbiter_int (
		.clk, .reset,
		.icache_pmem_read, .icache_pmem_address,
		.dcache_pmem_read, .dcache_pmem_write, .dcache_pmem_address,
		.pmem_resp, .icache_pmem_resp, .dcache_pmem_resp,
		.pmem_read, .pmem_write, .pmem_address,
		.ld_regs(load_regs)
	);

	fetch fetch_int (
		.clk, .reset, .load_regs, .dep_stall, .br_taken, .target_pc,
		.resp(icache_pmem_resp), .rdata(pmem_rdata),
		.read(icache_pmem_read), .address(icache_pmem_address),
		.npc(f_de_npc), .ir(f_de_ir), .valid(f_de_valid)
	);

	decode decode_int (
		.clk, .reset, .load_regs,
		.npc_in(f_de_npc), .ir_in(f_de_ir), .valid_in(f_de_valid),
		.sr1_data, .sr2_data, .cc_data, .sr1_id, .sr2_id,
		.ex_dr, .ex_ld_reg, .ex_ld_cc, .mem_dr, .mem_ld_reg, .mem_ld_cc,
		.wb_dr, .wb_ld_reg, .wb_ld_cc, .br_taken, .dep_stall,
		.npc(de_ex_npc), .cw(de_ex_cw), .ir(de_ex_ir), .sr1(de_ex_sr1),
		.sr2(de_ex_sr2), .cc(de_ex_cc), .dr(de_ex_dr), .valid(de_ex_valid)
	);

	execute execute_int (
		.clk, .reset, .load_regs,
		.npc_in(de_ex_npc), .cw_in(de_ex_cw), .ir_in(de_ex_ir),
		.sr1(de_ex_sr1), .sr2(de_ex_sr2), .cc_in(de_ex_cc),
		.dr_in(de_ex_dr), .valid_in(de_ex_valid),
		.br_taken, .target_pc, .ex_dr, .ex_ld_reg, .ex_ld_cc,
		.address(ex_mem_address), .cw(ex_mem_cw), .result(ex_mem_result),
		.data(ex_mem_data), .dr(ex_mem_dr), .valid(ex_mem_valid)
	);

	mem mem_int (
		.clk, .reset, .load_regs,
		.address_in(ex_mem_address), .cw_in(ex_mem_cw), .result_in(ex_mem_result),
		.data_in(ex_mem_data), .dr_in(ex_mem_dr), .valid_in(ex_mem_valid),
		.resp(dcache_pmem_resp), .rdata(pmem_rdata),
		.read(dcache_pmem_read), .write(dcache_pmem_write),
		.pmem_address(dcache_pmem_address), .wdata(pmem_wdata),
		.mem_dr, .mem_ld_reg, .mem_ld_cc,
		.cw(mem_wb_cw), .result(mem_wb_result), .data(mem_wb_data),
		.dr(mem_wb_dr), .valid(mem_wb_valid)
	);

	write_back write_back_int (
		.clk, .reset,
		.cw(mem_wb_cw), .result(mem_wb_result), .data(mem_wb_data),
		.dr(mem_wb_dr), .valid(mem_wb_valid),
		.sr1_id, .sr2_id, .sr1_data, .sr2_data, .cc_data,
		.wb_dr, .wb_ld_reg, .wb_ld_cc
	);

endmodule : mp3

// ==== src/write_back.sv ====
module write_back (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_control_word cw,
	input lc3b_types::lc3b_word result,
	input lc3b_types::lc3b_word data,
	input lc3b_types::lc3b_reg dr,
	input logic valid,
	input lc3b_types::lc3b_reg sr1_id,
	input lc3b_types::lc3b_reg sr2_id,
	output lc3b_types::lc3b_word sr1_data,
	output lc3b_types::lc3b_word sr2_data,
	output lc3b_types::lc3b_nzp cc_data,
	output lc3b_types::lc3b_reg wb_dr,
	output logic wb_ld_reg,
	output logic wb_ld_cc
);
	lc3b_types::lc3b_word regs [8];
	lc3b_types::lc3b_word reg_data;
	lc3b_types::lc3b_reg dest_reg;
	lc3b_types::lc3b_nzp cc_reg;
	lc3b_types::lc3b_nzp gen_cc;

	assign reg_data = (cw.wb_sel == lc3b_types::wb_mem) ? data : result;
	assign dest_reg = dr;
	assign wb_dr = dr;
	assign wb_ld_reg = valid && cw.load_regfile;
	assign wb_ld_cc = valid && cw.load_cc;

	assign gen_cc = {reg_data[15], reg_data == 16'h0000, !reg_data[15] && reg_data != 16'h0000};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			cc_reg <= 3'b010;
		end else begin
			if (wb_ld_reg)
				regs[dest_reg] <= reg_data;
			if (wb_ld_cc)
				cc_reg <= gen_cc;
		end
	end

	// same-cycle write shows up on the read side
	assign sr1_data = (wb_ld_reg && dest_reg == sr1_id) ? reg_data : regs[sr1_id];
	assign sr2_data = (wb_ld_reg && dest_reg == sr2_id) ? reg_data : regs[sr2_id];
	assign cc_data = wb_ld_cc ? gen_cc : cc_reg;

endmodule : write_back

// ==== src/arbiter.sv ====
module arbiter (
	input logic clk,
	input logic reset,
	input logic icache_pmem_read,
	input lc3b_types::lc3b_word icache_pmem_address,
	input logic dcache_pmem_read,
	input logic dcache_pmem_write,
	input lc3b_types::lc3b_word dcache_pmem_address,
	input logic pmem_resp,
	output logic icache_pmem_resp,
	output logic dcache_pmem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output logic ld_regs
);
	logic busy;
	logic owner_d;
	logic d_req;
	logic sel_d;

	assign d_req = dcache_pmem_read || dcache_pmem_write;

	// open grant holds, otherwise data side goes first
	assign sel_d = busy ? owner_d : d_req;

	assign pmem_read = sel_d ? dcache_pmem_read : icache_pmem_read;
	assign pmem_write = sel_d && dcache_pmem_write;
	assign pmem_address = sel_d ? dcache_pmem_address : icache_pmem_address;

	assign icache_pmem_resp = pmem_resp && !sel_d;
	assign dcache_pmem_resp = pmem_resp && sel_d;

	// pipeline moves only with both sides quiet
	assign ld_regs = !icache_pmem_read && !d_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner_d <= 1'b0;
		end else if (pmem_resp) begin
			busy <= 1'b0;
		end else if (pmem_read || pmem_write) begin
			busy <= 1'b1;
			owner_d <= sel_d;
		end
	end

endmodule : arbiter

// ==== src/mem.sv ====
module mem (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word address_in,
	input lc3b_types::lc3b_control_word cw_in,
	input lc3b_types::lc3b_word result_in,
	input lc3b_types::lc3b_word data_in,
	input lc3b_types::lc3b_reg dr_in,
	input logic valid_in,
	input logic resp,
	input lc3b_types::lc3b_c_block rdata,
	output logic read,
	output logic write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_c_block wdata,
	output lc3b_types::lc3b_reg mem_dr,
	output logic mem_ld_reg,
	output logic mem_ld_cc,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_word data,
	output lc3b_types::lc3b_reg dr,
	output logic valid
);
	lc3b_types::mem_state state;
	lc3b_types::lc3b_c_block line_buf;
	lc3b_types::lc3b_word word_buf;
	lc3b_types::lc3b_word rdata_word;
	logic done;
	logic start;

	assign start = valid_in && (cw_in.mem_read || cw_in.mem_write) && !done;
	assign pmem_address = {address_in[15:4], 4'b0000};
	assign mem_dr = dr_in;
	assign mem_ld_reg = valid_in && cw_in.load_regfile;
	assign mem_ld_cc = valid_in && cw_in.load_cc;

	// pick the addressed word, and drop the store word into the held line
	always_comb begin
		rdata_word = rdata[15:0];
		wdata = line_buf;
		for (int i = 0; i < lc3b_types::words_per_line; i++) begin
			if (address_in[3:1] == i[2:0]) begin
				rdata_word = rdata[16*i +: 16];
				wdata[16*i +: 16] = data_in;
			end
		end
	end

	always_comb begin
		read = 1'b0;
		write = 1'b0;
		case (state)
			lc3b_types::ms_idle: read = start;
			lc3b_types::ms_read: read = 1'b1;
			default: write = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lc3b_types::ms_idle;
			done <= 1'b0;
		end else if (load_regs) begin
			done <= 1'b0;
		end else begin
			case (state)
				lc3b_types::ms_idle, lc3b_types::ms_read: begin
					if (resp && cw_in.mem_write) begin
						state <= lc3b_types::ms_merge;
					end else if (resp) begin
						state <= lc3b_types::ms_idle;
						done <= 1'b1;
					end else if (read) begin
						state <= lc3b_types::ms_read;
					end
				end
				default: begin
					if (resp) begin
						state <= lc3b_types::ms_idle;
						done <= 1'b1;
					end else begin
						state <= lc3b_types::ms_write;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resp && read)
			line_buf <= rdata;
		else if (state == lc3b_types::ms_merge)
			line_buf <= wdata;
		if (resp && read)
			word_buf <= rdata_word;
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else if (load_regs)
			valid <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (load_regs) begin
			cw <= cw_in;
			result <= result_in;
			data <= word_buf;
			dr <= dr_in;
		end
	end

endmodule : mem

// ==== src/execute.sv ====
module execute (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_control_word cw_in,
	input lc3b_types::lc3b_word ir_in,
	input lc3b_types::lc3b_word sr1,
	input lc3b_types::lc3b_word sr2,
	input lc3b_types::lc3b_nzp cc_in,
	input lc3b_types::lc3b_reg dr_in,
	input logic valid_in,
	output logic br_taken,
	output lc3b_types::lc3b_word target_pc,
	output lc3b_types::lc3b_reg ex_dr,
	output logic ex_ld_reg,
	output logic ex_ld_cc,
	output lc3b_types::lc3b_word address,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_word data,
	output lc3b_types::lc3b_reg dr,
	output logic valid
);
	lc3b_types::lc3b_word imm5;
	lc3b_types::lc3b_word off6;
	lc3b_types::lc3b_word off9;
	lc3b_types::lc3b_word alu_b;
	lc3b_types::lc3b_word alu_out;

	assign imm5 = {{11{ir_in[4]}}, ir_in[4:0]};
	// word offsets, scaled to bytes
	assign off6 = {{9{ir_in[5]}}, ir_in[5:0], 1'b0};
	assign off9 = {{6{ir_in[8]}}, ir_in[8:0], 1'b0};
	assign alu_b = cw_in.imm_sel ? imm5 : sr2;

	always_comb begin
		case (cw_in.aluop)
			lc3b_types::alu_add: alu_out = sr1 + alu_b;
			lc3b_types::alu_and: alu_out = sr1 & alu_b;
			lc3b_types::alu_not: alu_out = ~sr1;
			default: alu_out = sr1;
		endcase
	end

	assign target_pc = npc_in + off9;
	assign br_taken = valid_in && cw_in.is_br && |(ir_in[11:9] & cc_in);

	assign ex_dr = dr_in;
	assign ex_ld_reg = valid_in && cw_in.load_regfile;
	assign ex_ld_cc = valid_in && cw_in.load_cc;

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else if (load_regs)
			valid <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (load_regs) begin
			address <= sr1 + off6;
			cw <= cw_in;
			result <= alu_out;
			data <= sr2;
			dr <= dr_in;
		end
	end

endmodule : execute

// ==== src/decode.sv ====
module decode (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_word ir_in,
	input logic valid_in,
	input lc3b_types::lc3b_word sr1_data,
	input lc3b_types::lc3b_word sr2_data,
	input lc3b_types::lc3b_nzp cc_data,
	output lc3b_types::lc3b_reg sr1_id,
	output lc3b_types::lc3b_reg sr2_id,
	input lc3b_types::lc3b_reg ex_dr,
	input logic ex_ld_reg,
	input logic ex_ld_cc,
	input lc3b_types::lc3b_reg mem_dr,
	input logic mem_ld_reg,
	input logic mem_ld_cc,
	input lc3b_types::lc3b_reg wb_dr,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	input logic br_taken,
	output logic dep_stall,
	output lc3b_types::lc3b_word npc,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_word sr1,
	output lc3b_types::lc3b_word sr2,
	output lc3b_types::lc3b_nzp cc,
	output lc3b_types::lc3b_reg dr,
	output logic valid
);
	lc3b_types::lc3b_opcode opcode;
	lc3b_types::lc3b_control_word cw_next;
	logic use_sr1;
	logic use_sr2;
	logic sr1_hit;
	logic sr2_hit;
	logic cc_pending;

	assign opcode = lc3b_types::lc3b_opcode'(ir_in[15:12]);
	assign sr1_id = ir_in[8:6];
	// str takes its store data from the dr field
	assign sr2_id = (opcode == lc3b_types::op_str) ? ir_in[11:9] : ir_in[2:0];

	always_comb begin
		cw_next = '0;
		cw_next.aluop = lc3b_types::alu_pass;
		cw_next.wb_sel = lc3b_types::wb_alu;
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		case (opcode)
			lc3b_types::op_add: begin
				cw_next.aluop = lc3b_types::alu_add;
				cw_next.imm_sel = ir_in[5];
				cw_next.load_regfile = 1'b1;
				cw_next.load_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = !ir_in[5];
			end
			lc3b_types::op_and: begin
				cw_next.aluop = lc3b_types::alu_and;
				cw_next.imm_sel = ir_in[5];
				cw_next.load_regfile = 1'b1;
				cw_next.load_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = !ir_in[5];
			end
			lc3b_types::op_not: begin
				cw_next.aluop = lc3b_types::alu_not;
				cw_next.load_regfile = 1'b1;
				cw_next.load_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			lc3b_types::op_br: cw_next.is_br = 1'b1;
			lc3b_types::op_ldr: begin
				cw_next.mem_read = 1'b1;
				cw_next.load_regfile = 1'b1;
				cw_next.load_cc = 1'b1;
				cw_next.wb_sel = lc3b_types::wb_mem;
				use_sr1 = 1'b1;
			end
			lc3b_types::op_str: begin
				cw_next.mem_write = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			// everything else goes through as a no-op
			default: ;
		endcase
	end

	assign sr1_hit = (ex_ld_reg && ex_dr == sr1_id) || (mem_ld_reg && mem_dr == sr1_id)
		|| (wb_ld_reg && wb_dr == sr1_id);
	assign sr2_hit = (ex_ld_reg && ex_dr == sr2_id) || (mem_ld_reg && mem_dr == sr2_id)
		|| (wb_ld_reg && wb_dr == sr2_id);
	assign cc_pending = ex_ld_cc || mem_ld_cc || wb_ld_cc;
	assign dep_stall = valid_in && ((use_sr1 && sr1_hit) || (use_sr2 && sr2_hit)
		|| (cw_next.is_br && cc_pending));

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else if (load_regs)
			valid <= valid_in && !dep_stall && !br_taken;
	end

	always_ff @(posedge clk) begin
		if (load_regs) begin
			npc <= npc_in;
			cw <= cw_next;
			ir <= ir_in;
			sr1 <= sr1_data;
			sr2 <= sr2_data;
			cc <= cc_data;
			dr <= ir_in[11:9];
		end
	end

endmodule : decode

// ==== src/fetch.sv ====
module fetch (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic dep_stall,
	input logic br_taken,
	input lc3b_types::lc3b_word target_pc,
	input logic resp,
	input lc3b_types::lc3b_c_block rdata,
	output logic read,
	output lc3b_types::lc3b_word address,
	output lc3b_types::lc3b_word npc,
	output lc3b_types::lc3b_word ir,
	output logic valid
);
	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_word pc_plus2;
	lc3b_types::lc3b_word word_buf;
	logic have;
	logic active;

	assign pc_plus2 = pc + 16'd2;
	assign address = {pc[15:4], 4'b0000};
	// one request per pc, dropped once the word is held
	assign read = active && !have;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			have <= 1'b0;
			pc <= lc3b_types::reset_pc;
			valid <= 1'b0;
		end else begin
			active <= 1'b1;
			if (resp)
				have <= 1'b1;
			if (load_regs) begin
				if (br_taken) begin
					// wrong-path word is thrown away
					pc <= target_pc;
					have <= 1'b0;
					valid <= 1'b0;
				end else if (!dep_stall) begin
					valid <= have;
					if (have) begin
						pc <= pc_plus2;
						have <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp)
			word_buf <= rdata[16*pc[3:1] +: 16];
		if (load_regs && !br_taken && !dep_stall) begin
			ir <= word_buf;
			npc <= pc_plus2;
		end
	end

endmodule : fetch

// ==== src/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;
typedef logic [127:0] lc3b_c_block;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_alu_op;

typedef enum logic {
	wb_alu,
	wb_mem
} lc3b_wb_sel;

typedef struct packed {
	lc3b_alu_op aluop;
	logic imm_sel;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic is_br;
	lc3b_wb_sel wb_sel;
} lc3b_control_word;

typedef enum logic [1:0] {
	ms_idle,
	ms_read,
	ms_merge,
	ms_write
} mem_state;

localparam lc3b_word reset_pc = 16'h0000;
localparam int words_per_line = 8;

endpackage : lc3b_types
